//--- decode_pkg.sv
package decode_pkg;

    localparam int XLEN     = 32;
    localparam int REG_W    = 5;
    localparam int N_SRC    = 2;
    localparam int IMM_W    = 16;
    localparam int JIDX_W   = 26;
    localparam int ALU_OP_W = 8;

    // one-hot alu op bits, 6 and 7 spare
    localparam int ALU_ADD = 0;
    localparam int ALU_SUB = 1;
    localparam int ALU_SLT = 2;
    localparam int ALU_AND = 3;
    localparam int ALU_OR  = 4;
    localparam int ALU_LUI = 5;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // branch kind handed from decoder to issue
    localparam int BR_KIND_W = 3;
    localparam logic [BR_KIND_W-1:0] BR_NONE = 3'd0;
    localparam logic [BR_KIND_W-1:0] BR_BEQ  = 3'd1;
    localparam logic [BR_KIND_W-1:0] BR_BNE  = 3'd2;
    localparam logic [BR_KIND_W-1:0] BR_J    = 3'd3;
    localparam logic [BR_KIND_W-1:0] BR_JR   = 3'd4;

    // bundle: ctrl, rs_value, rt_value, pc, zero pad (msb first)
    localparam int CTRL_W       = ALU_OP_W + 7 + REG_W + IMM_W;
    localparam int BUNDLE_PAD_W = 20;
    localparam int BUS_PC_LSB   = BUNDLE_PAD_W;
    localparam int BUS_RT_LSB   = BUS_PC_LSB + XLEN;
    localparam int BUS_RS_LSB   = BUS_RT_LSB + XLEN;
    localparam int CTRL_LSB     = BUS_RS_LSB + XLEN;
    localparam int BUS_DEST_LSB = CTRL_LSB + IMM_W;
    localparam int BUNDLE_W     = CTRL_LSB + CTRL_W;

    typedef union packed {
        struct packed {
            logic [5:0]       op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [REG_W-1:0] rd;
            logic [4:0]       sa;
            logic [5:0]       funct;
        } r;
        struct packed {
            logic [5:0]       op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [IMM_W-1:0] imm16;
        } i;
    } inst_word_t;

endpackage

//--- operand_if.sv
`timescale 1ns/1ps

interface operand_if import decode_pkg::*;;

    logic [REG_W-1:0] idx;
    logic             used;
    logic [XLEN-1:0]  value;
    logic             hazard;

    modport decoder (
        output idx,
        output used
    );

    modport forward (
        input  idx,
        input  used,
        output value,
        output hazard
    );

    modport issue (
        input  value,
        input  hazard
    );

endinterface

//--- id_decoder.sv
`timescale 1ns/1ps

module id_decoder import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_valid,
    input  logic [XLEN-1:0]       fs_pc,
    input  logic [XLEN-1:0]       fs_inst,
    input  logic                  es_allowin,
    input  logic                  ready_go,
    output logic                  ds_allowin,
    output logic                  slot_valid,
    output logic [XLEN-1:0]       slot_pc,
    operand_if.decoder            ops [N_SRC],
    output logic [CTRL_W-1:0]     ctrl,
    output logic [BR_KIND_W-1:0]  branch_kind,
    output logic [JIDX_W-1:0]     jidx
);

    logic            valid_q;
    inst_word_t      inst_q;
    logic [XLEN-1:0] pc_q;

    logic is_special;
    logic r_clean;
    logic inst_addu, inst_subu, inst_slt, inst_and, inst_or, inst_jr;
    logic inst_addiu, inst_lui, inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_j, inst_jal;
    logic [ALU_OP_W-1:0] alu_op;
    logic src2_is_imm;
    logic gr_we;
    logic [REG_W-1:0] dest;

    assign ds_allowin = !valid_q || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (ds_allowin) begin
            valid_q <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            inst_q <= fs_inst;
            pc_q   <= fs_pc;
        end
    end

    assign slot_valid = valid_q;
    assign slot_pc    = pc_q;

    // r view for funct-selected ops
    assign is_special = inst_q.r.op == OP_SPECIAL;
    assign r_clean    = inst_q.r.sa == '0;
    assign inst_addu  = is_special && r_clean && inst_q.r.funct == FN_ADDU;
    assign inst_subu  = is_special && r_clean && inst_q.r.funct == FN_SUBU;
    assign inst_slt   = is_special && r_clean && inst_q.r.funct == FN_SLT;
    assign inst_and   = is_special && r_clean && inst_q.r.funct == FN_AND;
    assign inst_or    = is_special && r_clean && inst_q.r.funct == FN_OR;
    assign inst_jr    = is_special && r_clean && inst_q.r.funct == FN_JR
                        && inst_q.r.rt == '0 && inst_q.r.rd == '0;

    // i view for the rest
    assign inst_addiu = inst_q.i.op == OP_ADDIU;
    assign inst_lui   = inst_q.i.op == OP_LUI && inst_q.i.rs == '0;
    assign inst_lw    = inst_q.i.op == OP_LW;
    assign inst_sw    = inst_q.i.op == OP_SW;
    assign inst_beq   = inst_q.i.op == OP_BEQ;
    assign inst_bne   = inst_q.i.op == OP_BNE;
    assign inst_j     = inst_q.i.op == OP_J;
    assign inst_jal   = inst_q.i.op == OP_JAL;

    always_comb begin
        alu_op          = '0;
        alu_op[ALU_ADD] = inst_addu || inst_addiu || inst_lw || inst_sw || inst_jal;
        alu_op[ALU_SUB] = inst_subu;
        alu_op[ALU_SLT] = inst_slt;
        alu_op[ALU_AND] = inst_and;
        alu_op[ALU_OR]  = inst_or;
        alu_op[ALU_LUI] = inst_lui;
    end

    assign src2_is_imm = inst_addiu || inst_lui || inst_lw || inst_sw;
    // unknown words fall through with no write
    assign gr_we = inst_addu || inst_subu || inst_slt || inst_and || inst_or
                   || inst_addiu || inst_lui || inst_lw || inst_jal;
    assign dest  = inst_jal ? REG_W'(31) :
                   (inst_addiu || inst_lui || inst_lw) ? inst_q.i.rt : inst_q.r.rd;

    // load, store, src1_is_pc, src2_is_imm, src2_is_uimm, src2_is_8, gr_we
    assign ctrl = {alu_op, inst_lw, inst_sw, inst_jal, src2_is_imm, 1'b0, inst_jal,
                   gr_we, dest, inst_q.i.imm16};

    assign branch_kind = inst_beq ? BR_BEQ :
                         inst_bne ? BR_BNE :
                         (inst_j || inst_jal) ? BR_J :
                         inst_jr  ? BR_JR : BR_NONE;
    assign jidx = {inst_q.i.rs, inst_q.i.rt, inst_q.i.imm16};

    // operand requests, quiet while the slot is empty
    assign ops[0].idx  = inst_q.i.rs;
    assign ops[0].used = valid_q && (inst_addu || inst_subu || inst_slt || inst_and
                         || inst_or || inst_addiu || inst_lw || inst_sw
                         || inst_beq || inst_bne || inst_jr);
    assign ops[1].idx  = inst_q.i.rt;
    assign ops[1].used = valid_q && (inst_addu || inst_subu || inst_slt || inst_and
                         || inst_or || inst_sw || inst_beq || inst_bne);

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile import decode_pkg::*; (
    input  logic                        clk,
    input  logic [N_SRC-1:0][REG_W-1:0] raddr,
    output logic [N_SRC-1:0][XLEN-1:0]  rdata,
    input  logic                        we,
    input  logic [REG_W-1:0]            waddr,
    input  logic [XLEN-1:0]             wdata
);

    // r0 has no storage
    logic [XLEN-1:0] regs [1:2**REG_W-1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        for (int p = 0; p < N_SRC; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

//--- operand_forward.sv
`timescale 1ns/1ps

module operand_forward import decode_pkg::*; (
    operand_if.forward       op,
    input  logic [XLEN-1:0]  rf_data,
    input  logic             es_fwd_valid,
    input  logic             es_is_load,
    input  logic [REG_W-1:0] es_dest,
    input  logic [XLEN-1:0]  es_result,
    input  logic             ms_fwd_valid,
    input  logic [REG_W-1:0] ms_dest,
    input  logic [XLEN-1:0]  ms_result,
    input  logic             ws_we,
    input  logic [REG_W-1:0] ws_dest,
    input  logic [XLEN-1:0]  ws_data
);

    logic live;
    logic es_hit;
    logic ms_hit;
    logic ws_hit;

    // r0 and unused operands never match
    assign live   = op.used && op.idx != '0;
    assign es_hit = live && es_fwd_valid && es_dest == op.idx;
    assign ms_hit = live && ms_fwd_valid && ms_dest == op.idx;
    assign ws_hit = live && ws_we && ws_dest == op.idx;

    // youngest producer first
    always_comb begin
        if (es_hit && !es_is_load) begin
            op.value = es_result;
        end else if (ms_hit) begin
            op.value = ms_result;
        end else if (ws_hit) begin
            op.value = ws_data;
        end else begin
            op.value = rf_data;
        end
    end

    // load result not ready until mem
    assign op.hazard = es_hit && es_is_load;

endmodule

//--- issue_unit.sv
`timescale 1ns/1ps

module issue_unit import decode_pkg::*; (
    operand_if.issue              ops [N_SRC],
    input  logic                  slot_valid,
    input  logic [XLEN-1:0]       slot_pc,
    input  logic [XLEN-1:0]       fs_pc,
    input  logic [CTRL_W-1:0]     ctrl,
    input  logic [BR_KIND_W-1:0]  branch_kind,
    input  logic [JIDX_W-1:0]     jidx,
    output logic                  ready_go,
    output logic                  ds_to_es_valid,
    output logic [BUNDLE_W-1:0]   ds_to_es_bus,
    output logic                  br_valid,
    output logic                  br_taken,
    output logic [XLEN-1:0]       br_target
);

    logic [XLEN-1:0]  rs_value;
    logic [XLEN-1:0]  rt_value;
    logic [IMM_W-1:0] imm;
    logic [XLEN-1:0]  br_offset;
    logic             rs_eq_rt;

    assign rs_value = ops[0].value;
    assign rt_value = ops[1].value;
    assign imm      = ctrl[IMM_W-1:0];

    assign ready_go       = !(ops[0].hazard || ops[1].hazard);
    assign ds_to_es_valid = slot_valid && ready_go;

    always_comb begin
        ds_to_es_bus                         = '0;
        ds_to_es_bus[CTRL_LSB +: CTRL_W]     = ctrl;
        ds_to_es_bus[BUS_RS_LSB +: XLEN]     = rs_value;
        ds_to_es_bus[BUS_RT_LSB +: XLEN]     = rt_value;
        ds_to_es_bus[BUS_PC_LSB +: XLEN]     = slot_pc;
    end

    assign rs_eq_rt  = rs_value == rt_value;
    assign br_offset = {{(XLEN-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00};

    always_comb begin
        br_taken  = 1'b0;
        br_target = '0;
        case (branch_kind)
            BR_BEQ: begin
                br_taken  = rs_eq_rt;
                br_target = fs_pc + br_offset;
            end
            BR_BNE: begin
                br_taken  = !rs_eq_rt;
                br_target = fs_pc + br_offset;
            end
            BR_J: begin
                br_taken  = 1'b1;
                br_target = {fs_pc[XLEN-1:JIDX_W+2], jidx, 2'b00};
            end
            BR_JR: begin
                br_taken  = 1'b1;
                br_target = rs_value;
            end
            default: ;
        endcase
        // nothing resolves from an empty slot
        br_taken = br_taken && slot_valid;
    end

    assign br_valid = slot_valid && branch_kind != BR_NONE;

endmodule

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage import decode_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                fs_valid,
    input  logic [XLEN-1:0]     fs_pc,
    input  logic [XLEN-1:0]     fs_inst,
    input  logic                es_allowin,
    input  logic                es_fwd_valid,
    input  logic                es_is_load,
    input  logic [REG_W-1:0]    es_dest,
    input  logic [XLEN-1:0]     es_result,
    input  logic                ms_fwd_valid,
    input  logic [REG_W-1:0]    ms_dest,
    input  logic [XLEN-1:0]     ms_result,
    input  logic                ws_we,
    input  logic [REG_W-1:0]    ws_dest,
    input  logic [XLEN-1:0]     ws_data,
    output logic                ds_allowin,
    output logic                ds_to_es_valid,
    output logic [BUNDLE_W-1:0] ds_to_es_bus,
    output logic                br_valid,
    output logic                br_taken,
    output logic [XLEN-1:0]     br_target
);

    logic                       ready_go;
    logic                       slot_valid;
    logic [XLEN-1:0]            slot_pc;
    logic [CTRL_W-1:0]          ctrl;
    logic [BR_KIND_W-1:0]       branch_kind;
    logic [JIDX_W-1:0]          jidx;
    logic [N_SRC-1:0][XLEN-1:0] rf_rdata;

    // index 0 is rs, index 1 is rt
    operand_if op_bus [N_SRC] ();

    id_decoder u_decoder (
        .clk(clk), .reset(reset), .fs_valid(fs_valid), .fs_pc(fs_pc), .fs_inst(fs_inst),
        .es_allowin(es_allowin), .ready_go(ready_go), .ds_allowin(ds_allowin),
        .slot_valid(slot_valid), .slot_pc(slot_pc), .ops(op_bus), .ctrl(ctrl),
        .branch_kind(branch_kind), .jidx(jidx)
    );

    regfile u_regfile (
        .clk(clk), .raddr({op_bus[1].idx, op_bus[0].idx}), .rdata(rf_rdata),
        .we(ws_we), .waddr(ws_dest), .wdata(ws_data)
    );

    for (genvar g = 0; g < N_SRC; g++) begin : g_fwd
        operand_forward u_fwd (
            .op(op_bus[g]), .rf_data(rf_rdata[g]),
            .es_fwd_valid(es_fwd_valid), .es_is_load(es_is_load),
            .es_dest(es_dest), .es_result(es_result),
            .ms_fwd_valid(ms_fwd_valid), .ms_dest(ms_dest), .ms_result(ms_result),
            .ws_we(ws_we), .ws_dest(ws_dest), .ws_data(ws_data)
        );
    end

    issue_unit u_issue (
        .ops(op_bus), .slot_valid(slot_valid), .slot_pc(slot_pc), .fs_pc(fs_pc),
        .ctrl(ctrl), .branch_kind(branch_kind), .jidx(jidx), .ready_go(ready_go),
        .ds_to_es_valid(ds_to_es_valid), .ds_to_es_bus(ds_to_es_bus),
        .br_valid(br_valid), .br_taken(br_taken), .br_target(br_target)
    );

endmodule

//--- id_stage_assertions.sv
`timescale 1ns/1ps

module id_stage_assertions (
    input logic clk,
    input logic reset,
    input logic slot_valid,
    input logic ready_go,
    input logic ds_allowin,
    input logic ds_to_es_valid
);

    // a slot that cannot hand off keeps its instruction
    stalled_slot_holds: assert property (@(posedge clk) disable iff (reset)
        slot_valid && !ds_to_es_valid |=> slot_valid)
        else $error("decode slot emptied while its instruction was stalled");

    // reset leaves the slot empty
    allowin_after_reset: assert property (@(posedge clk) reset |=> ds_allowin)
        else $error("ds_allowin low in the cycle after reset");

    // an operand hazard blocks both issue and intake
    hazard_blocks_issue: assert property (@(posedge clk) disable iff (reset)
        !ready_go |-> !ds_to_es_valid && !ds_allowin)
        else $error("decode stage issued or accepted during an operand hazard");

endmodule

bind id_stage id_stage_assertions u_assertions (
    .clk(clk), .reset(reset), .slot_valid(slot_valid), .ready_go(ready_go),
    .ds_allowin(ds_allowin), .ds_to_es_valid(ds_to_es_valid)
);

//--- tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int WAIT_LIMIT   = 20;
    localparam int MAX_LINES    = 1000;

    logic         clk;
    logic         reset;
    logic         fs_valid;
    logic [31:0]  fs_pc;
    logic [31:0]  fs_inst;
    logic         es_allowin;
    logic         es_fwd_valid;
    logic         es_is_load;
    logic [4:0]   es_dest;
    logic [31:0]  es_result;
    logic         ms_fwd_valid;
    logic [4:0]   ms_dest;
    logic [31:0]  ms_result;
    logic         ws_we;
    logic [4:0]   ws_dest;
    logic [31:0]  ws_data;
    logic         ds_allowin;
    logic         ds_to_es_valid;
    logic [151:0] ds_to_es_bus;
    logic         br_valid;
    logic         br_taken;
    logic [31:0]  br_target;

    int    errors;
    int    fd;
    int    line_no;
    string name;

    logic [31:0] in_fv, in_pc, in_inst, in_ea, in_efv, in_eld, in_ed, in_eres;
    logic [31:0] in_mfv, in_md, in_mres, in_wwe, in_wd, in_wdat;
    logic [31:0] exp_alw, exp_vld, exp_bv, exp_bt, exp_tgt;
    logic [31:0] exp_rs, exp_rt, exp_dst, exp_alu, exp_flg;

    // instruction the slot should be holding
    logic [31:0] held_pc;
    logic [31:0] held_inst;

    id_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_field(input string field, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH test %s (trace line %0d) %s: expected %h, actual %h",
                     name, line_no, field, exp, got);
        end
    endtask

    task automatic apply_inputs();
        fs_valid     <= in_fv[0];
        fs_pc        <= in_pc;
        fs_inst      <= in_inst;
        es_allowin   <= in_ea[0];
        es_fwd_valid <= in_efv[0];
        es_is_load   <= in_eld[0];
        es_dest      <= in_ed[4:0];
        es_result    <= in_eres;
        ms_fwd_valid <= in_mfv[0];
        ms_dest      <= in_md[4:0];
        ms_result    <= in_mres;
        ws_we        <= in_wwe[0];
        ws_dest      <= in_wd[4:0];
        ws_data      <= in_wdat;
    endtask

    // bundle, msb first: alu_op 8, flags 7, dest 5, imm 16, rs 32, rt 32, pc 32, pad 20
    task automatic check_outputs();
        check_field("ds_allowin", exp_alw, 32'(ds_allowin));
        check_field("ds_to_es_valid", exp_vld, 32'(ds_to_es_valid));
        check_field("br_valid", exp_bv, 32'(br_valid));
        check_field("br_taken", exp_bt, 32'(br_taken));
        if (exp_bv[0]) begin
            check_field("br_target", exp_tgt, br_target);
        end
        if (exp_vld[0]) begin
            check_field("alu_op", exp_alu, 32'(ds_to_es_bus[151:144]));
            check_field("flags", exp_flg, 32'(ds_to_es_bus[143:137]));
            check_field("imm", 32'(held_inst[15:0]), 32'(ds_to_es_bus[131:116]));
            check_field("rs_value", exp_rs, ds_to_es_bus[115:84]);
            check_field("rt_value", exp_rt, ds_to_es_bus[83:52]);
            check_field("pc", held_pc, ds_to_es_bus[51:20]);
            check_field("pad", 32'h0, 32'(ds_to_es_bus[19:0]));
            // dest only names a register when gr_we is set
            if (exp_flg[0]) begin
                check_field("dest", exp_dst, 32'(ds_to_es_bus[136:132]));
            end
        end
    endtask

    task automatic run_trace();
        string text;
        int    n;
        while (!$feof(fd) && line_no < MAX_LINES) begin
            text = "";
            void'($fgets(text, fd));
            line_no++;
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(text,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, in_fv, in_pc, in_inst, in_ea, in_efv, in_eld, in_ed, in_eres,
                in_mfv, in_md, in_mres, in_wwe, in_wd, in_wdat,
                exp_alw, exp_vld, exp_bv, exp_bt, exp_tgt,
                exp_rs, exp_rt, exp_dst, exp_alu, exp_flg);
            if (n != 25) begin
                errors++;
                $display("trace line %0d is malformed: %0d fields read", line_no, n);
                continue;
            end
            @(posedge clk);
            apply_inputs();
            @(negedge clk);
            check_outputs();
            // the slot takes this line's instruction at the next edge
            if (in_fv[0] && exp_alw[0]) begin
                held_pc   = in_pc;
                held_inst = in_inst;
            end
        end
    endtask

    task automatic drain_slot();
        int waited;
        waited = 0;
        @(posedge clk);
        fs_valid     <= 1'b0;
        es_allowin   <= 1'b1;
        es_fwd_valid <= 1'b0;
        @(negedge clk);
        while ((ds_allowin !== 1'b1 || br_valid !== 1'b0) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ds_allowin !== 1'b1 || br_valid !== 1'b0) begin
            errors++;
            $display("timed out waiting for the decode slot to drain");
        end
    endtask

    initial begin : main
        int waited;
        errors       = 0;
        line_no      = 0;
        waited       = 0;
        held_pc      = '0;
        held_inst    = '0;
        reset        = 1'b1;
        fs_valid     = 1'b0;
        fs_pc        = '0;
        fs_inst      = '0;
        es_allowin   = 1'b1;
        es_fwd_valid = 1'b0;
        es_is_load   = 1'b0;
        es_dest      = '0;
        es_result    = '0;
        ms_fwd_valid = 1'b0;
        ms_dest      = '0;
        ms_result    = '0;
        ws_we        = 1'b0;
        ws_dest      = '0;
        ws_data      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (ds_allowin !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ds_allowin !== 1'b1) begin
            errors++;
            $display("timed out waiting for ds_allowin after reset");
        end else begin
            fd = $fopen("id_trace.txt", "r");
            if (fd == 0) begin
                errors++;
                $display("could not open id_trace.txt");
            end else begin
                run_trace();
                $fclose(fd);
                drain_slot();
            end
        end
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- id_stage.f
decode_pkg.sv
operand_if.sv
id_decoder.sv
regfile.sv
operand_forward.sv
issue_unit.sv
id_stage.sv
id_stage_assertions.sv
tb_id_stage.sv

//--- Makefile
SIM  := obj_dir/Vtb_id_stage
SRCS := $(filter-out +%,$(shell cat id_stage.f))

.PHONY: all run clean

all: $(SIM)

$(SIM): id_stage.f $(SRCS)
	verilator --binary --assert --timing --top-module tb_id_stage -f id_stage.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- id_trace.txt
# test fs_valid fs_pc fs_inst es_allowin | es: valid load dest result | ms: valid dest result | ws: we dest data
# expect: allowin to_es_valid br_valid br_taken br_target rs_value rt_value dest alu_op flags (all hex)
rf_read 0 0 0 1 0 0 0 0 0 0 0 1 1 11 1 0 0 0 0 0 0 0 0 0
rf_read 0 0 0 1 0 0 0 0 0 0 0 1 2 22 1 0 0 0 0 0 0 0 0 0
rf_read 0 0 0 1 0 0 0 0 0 0 0 1 4 44 1 0 0 0 0 0 0 0 0 0
rf_read 1 100 00221821 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
rf_read 1 104 24240010 1 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 11 22 3 01 01
rf_read 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 11 44 4 01 09
forward 1 108 00221821 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
forward 1 10c 00221821 1 1 0 1 eeee 1 1 dddd 1 1 11 1 1 0 0 0 eeee 22 3 01 01
forward 0 0 0 1 1 1 1 eeee 1 1 dddd 1 1 11 0 0 0 0 0 0 0 0 0 0
forward 1 110 00023021 1 0 0 0 0 1 1 dddd 1 1 11 1 1 0 0 0 dddd 22 3 01 01
forward 0 0 0 1 1 1 0 eeee 1 0 dddd 1 0 cccc 1 1 0 0 0 0 22 6 01 01
load_use 1 114 00443825 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
load_use 1 118 24240010 1 1 1 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
load_use 1 118 24240010 1 1 1 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
load_use 1 118 24240010 1 0 0 0 0 1 4 5a5a 0 0 0 1 1 0 0 0 22 5a5a 7 10 01
load_use 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 11 44 4 01 09
backpressure 1 11c 00224023 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
backpressure 1 120 00224824 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 11 22 8 02 01
backpressure 1 120 00224824 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 11 22 8 02 01
backpressure 1 120 00224824 1 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 11 22 8 02 01
backpressure 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 11 22 9 08 01
branch 1 bfc00200 10220004 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
branch 1 bfc00204 1422fffc 1 0 0 0 0 0 0 0 0 0 0 1 1 1 0 bfc00214 11 22 0 00 00
branch 1 bfc00208 10210008 1 0 0 0 0 0 0 0 0 0 0 1 1 1 1 bfc001f8 11 22 0 00 00
branch 1 bfc0020c 14420010 1 0 0 0 0 0 0 0 0 0 0 1 1 1 1 bfc0022c 11 11 0 00 00
branch 1 bfc00210 08000040 1 0 0 0 0 0 0 0 0 0 0 1 1 1 0 bfc00250 22 22 0 00 00
branch 1 bfc00214 0c000080 1 0 0 0 0 0 0 0 0 0 0 1 1 1 1 b0000100 0 0 0 00 00
branch 1 bfc00218 00a00008 1 0 0 0 0 0 0 0 0 0 0 1 1 1 1 b0000200 0 0 1f 01 13
branch 0 bfc0021c 0 1 1 0 5 400100 0 0 0 0 0 0 1 1 1 1 400100 400100 0 0 00 00
idle 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
